// File: rtl/ids_pkg.sv
package ids_pkg;

   // Stream id width, 64 interleaved streams
   localparam int STREAM_W = 6;

   // Depth of the per-stream state memory
   localparam int NUM_STREAMS = 64;

   // Committed match counter width
   localparam int COUNT_W = 16;

   // Dropped verdict counter width
   localparam int DROP_W = 8;

   // Number of letters in "rlogin"
   localparam int KEY_LEN = 6;

   // Keyword progress, value equals the number of letters already seen
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_R     = 3'd1,
      ST_RL    = 3'd2,
      ST_RLO   = 3'd3,
      ST_RLOG  = 3'd4,
      ST_RLOGI = 3'd5
   } dfa_state_e;

   // Byte class opcodes from the decoder
   typedef enum logic [2:0] {
      CL_R     = 3'd0,
      CL_L     = 3'd1,
      CL_O     = 3'd2,
      CL_G     = 3'd3,
      CL_I     = 3'd4,
      CL_N     = 3'd5,
      CL_OTHER = 3'd6
   } byte_class_e;

   // Result handshake phases
   typedef enum logic [1:0] {
      RP_IDLE     = 2'd0,
      RP_REQ      = 2'd1,
      RP_WAIT_LOW = 2'd2
   } rep_state_e;

   // Expected class for each progress state, indexed by dfa_state_e
   localparam byte_class_e KEY_SEQ [KEY_LEN] = '{CL_R, CL_L, CL_O, CL_G, CL_I, CL_N};

endpackage

// File: rtl/byte_class_decoder.sv
module byte_class_decoder (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [7:0]          char_in,
   input  logic                char_in_vld,
   input  logic                eop,
   output ids_pkg::byte_class_e class_out,
   output logic                class_vld,
   output logic                eop_d
);

   import ids_pkg::*;

   // Lower case copy of the incoming byte
   logic [7:0]  folded;
   // Class of the folded byte before the register
   byte_class_e class_next;

   always_comb
   begin
      folded = char_in;
      // 'A'..'Z' map onto 'a'..'z' by setting bit 5
      if ((char_in >= 8'h41) && (char_in <= 8'h5a))
      begin
         folded = char_in | 8'h20;
      end
   end

   always_comb
   begin
      case (folded)
         8'h72:   class_next = CL_R;   // r
         8'h6c:   class_next = CL_L;   // l
         8'h6f:   class_next = CL_O;   // o
         8'h67:   class_next = CL_G;   // g
         8'h69:   class_next = CL_I;   // i
         8'h6e:   class_next = CL_N;   // n
         default: class_next = CL_OTHER;
      endcase
   end

   // Valid and end of packet flags follow the byte by one cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         class_vld <= 1'b0;
         eop_d     <= 1'b0;
      end
      else
      begin
         class_vld <= char_in_vld;
         eop_d     <= eop & char_in_vld;
      end
   end

   // Opcode only moves on a real byte
   always_ff @(posedge clk)
   begin
      if (char_in_vld)
      begin
         class_out <= class_next;
      end
   end

   // End of packet must ride on the last byte
   a_eop_with_byte : assert property (@(posedge clk) disable iff (!rst_n)
      eop |-> char_in_vld);

endmodule

// File: rtl/keyword_dfa.sv
module keyword_dfa (
   input  logic                 clk,
   input  logic                 rst_n,
   input  ids_pkg::byte_class_e class_in,
   input  logic                 class_vld,
   input  ids_pkg::dfa_state_e  state_in,
   input  logic                 state_in_vld,
   output ids_pkg::dfa_state_e  state_out,
   output logic                 accept
);

   import ids_pkg::*;

   // Progress through the keyword for the packet in flight
   dfa_state_e  cur_state;
   dfa_state_e  next_state;
   // Letter that would move us one step forward
   byte_class_e want_class;
   // Current byte is the expected letter
   logic        hit;

   always_comb
   begin
      want_class = KEY_SEQ[cur_state];
      hit        = class_vld && (class_in == want_class);
      // Last letter seen while holding "rlogi"
      accept     = hit && (cur_state == ST_RLOGI);
      next_state = cur_state;
      if (class_vld)
      begin
         if (accept)
         begin
            // Full keyword, start looking for the next one
            next_state = ST_IDLE;
         end
         else if (hit)
         begin
            next_state = dfa_state_e'(cur_state + 3'd1);
         end
         else if (class_in == CL_R)
         begin
            // A stray r can still begin a new keyword
            next_state = ST_R;
         end
         else
         begin
            next_state = ST_IDLE;
         end
      end
   end

   // Context sees the post-step state, used when saving at end of packet
   assign state_out = next_state;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cur_state <= ST_IDLE;
      end
      else if (state_in_vld)
      begin
         // Restore or clear from the stream context
         cur_state <= state_in;
      end
      else if (class_vld)
      begin
         cur_state <= next_state;
      end
   end

   // Restore happens before the first byte of a packet reaches us
   a_load_not_step : assert property (@(posedge clk) disable iff (!rst_n)
      state_in_vld |-> !class_vld);

endmodule

// File: rtl/stream_match_ctx.sv
module stream_match_ctx (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load_state,
   input  logic [ids_pkg::STREAM_W-1:0] stream_id,
   input  logic                         new_stream_id,
   input  logic                         enable,
   input  logic                         eop_d,
   input  logic                         accept,
   input  ids_pkg::dfa_state_e          state_out,
   output ids_pkg::dfa_state_e          state_in,
   output logic                         state_in_vld,
   output logic [ids_pkg::COUNT_W-1:0]  count_out,
   output logic                         commit_vld,
   output logic [ids_pkg::STREAM_W-1:0] commit_stream,
   output logic                         commit_fired
);

   import ids_pkg::*;

   // Saved keyword progress, one entry per stream
   dfa_state_e          state_mem [NUM_STREAMS];

   // Stream and enable of the packet in flight
   logic [STREAM_W-1:0] cur_stream;
   logic                cur_enable;

   // Packet has matched at least once so far
   logic                spec_match;

   // Match seen anywhere in the packet, including its last byte
   logic                fired;

   assign fired = spec_match | accept;

   // Latch per-packet context at packet start
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         cur_stream <= stream_id;
         cur_enable <= enable;
      end
   end

   // Restore path, a new stream starts from scratch
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= load_state;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         state_in <= new_stream_id ? ST_IDLE : state_mem[stream_id];
      end
   end

   // Save only for enabled packets, otherwise the old entry stands
   always_ff @(posedge clk)
   begin
      if (eop_d && cur_enable)
      begin
         state_mem[cur_stream] <= state_out;
      end
   end

   // Speculative flag, match counter and commit pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_match <= 1'b0;
         count_out  <= '0;
         commit_vld <= 1'b0;
      end
      else
      begin
         commit_vld <= eop_d;
         if (load_state)
         begin
            spec_match <= 1'b0;
         end
         else if (eop_d)
         begin
            // Flag is consumed by the commit
            spec_match <= 1'b0;
            if (cur_enable)
            begin
               // At most one count per packet
               count_out <= count_out + COUNT_W'(fired);
            end
         end
         else if (accept)
         begin
            spec_match <= 1'b1;
         end
      end
   end

   // Verdict payload for the reporter
   always_ff @(posedge clk)
   begin
      if (eop_d)
      begin
         commit_stream <= cur_stream;
         commit_fired  <= cur_enable & fired;
      end
   end

   // Next packet start keeps clear of the previous end of packet
   a_load_vs_eop : assert property (@(posedge clk) disable iff (!rst_n)
      !(load_state && eop_d));

endmodule

// File: rtl/verdict_reporter.sv
module verdict_reporter (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         commit_vld,
   input  logic [ids_pkg::STREAM_W-1:0] commit_stream,
   input  logic                         commit_fired,
   output logic                         verdict_req,
   input  logic                         verdict_ack,
   output logic [ids_pkg::STREAM_W-1:0] verdict_stream,
   output logic                         verdict_fired,
   output logic [ids_pkg::DROP_W-1:0]   drop_count
);

   import ids_pkg::*;

   // Four-phase handshake position
   rep_state_e rep_state;

   // Any phase other than idle owns the single buffer slot
   logic       busy;

   assign busy        = (rep_state != RP_IDLE);
   assign verdict_req = (rep_state == RP_REQ);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rep_state  <= RP_IDLE;
         drop_count <= '0;
      end
      else
      begin
         case (rep_state)
            RP_IDLE:
            begin
               if (commit_vld)
               begin
                  rep_state <= RP_REQ;
               end
            end
            RP_REQ:
            begin
               // Ack seen so req drops next
               if (verdict_ack)
               begin
                  rep_state <= RP_WAIT_LOW;
               end
            end
            RP_WAIT_LOW:
            begin
               // Wait for ack to fall before freeing the slot
               if (!verdict_ack)
               begin
                  rep_state <= RP_IDLE;
               end
            end
            default:
            begin
               rep_state <= RP_IDLE;
            end
         endcase
         if (commit_vld && busy)
         begin
            drop_count <= drop_count + DROP_W'(1);
         end
      end
   end

   // Capture a verdict only into a free slot
   always_ff @(posedge clk)
   begin
      if (commit_vld && !busy)
      begin
         verdict_stream <= commit_stream;
         verdict_fired  <= commit_fired;
      end
   end

   // Ack may only rise while a request is up
   a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(verdict_ack) |-> verdict_req);

endmodule

// File: rtl/ids_top.sv
module ids_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [7:0]                   char_in,
   input  logic                         char_in_vld,
   input  logic                         eop,
   input  logic                         load_state,
   input  logic [ids_pkg::STREAM_W-1:0] stream_id,
   input  logic                         new_stream_id,
   input  logic                         enable,
   output logic                         verdict_req,
   input  logic                         verdict_ack,
   output logic [ids_pkg::STREAM_W-1:0] verdict_stream,
   output logic                         verdict_fired,
   output logic [ids_pkg::COUNT_W-1:0]  count_out,
   output logic [ids_pkg::DROP_W-1:0]   drop_count
);

   import ids_pkg::*;

   // Decode to execute
   byte_class_e         class_op;
   logic                class_vld;
   logic                eop_d;

   // Execute and context exchange
   dfa_state_e          state_in;
   logic                state_in_vld;
   dfa_state_e          state_out;
   logic                accept;

   // Context to reporter
   logic                commit_vld;
   logic [STREAM_W-1:0] commit_stream;
   logic                commit_fired;

   byte_class_decoder u_decoder (
      .clk         (clk),
      .rst_n       (rst_n),
      .char_in     (char_in),
      .char_in_vld (char_in_vld),
      .eop         (eop),
      .class_out   (class_op),
      .class_vld   (class_vld),
      .eop_d       (eop_d)
   );

   keyword_dfa u_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .class_in     (class_op),
      .class_vld    (class_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

   // Per-stream save and restore around the DFA
   stream_match_ctx u_ctx (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .enable        (enable),
      .eop_d         (eop_d),
      .accept        (accept),
      .state_out     (state_out),
      .state_in      (state_in),
      .state_in_vld  (state_in_vld),
      .count_out     (count_out),
      .commit_vld    (commit_vld),
      .commit_stream (commit_stream),
      .commit_fired  (commit_fired)
   );

   verdict_reporter u_reporter (
      .clk            (clk),
      .rst_n          (rst_n),
      .commit_vld     (commit_vld),
      .commit_stream  (commit_stream),
      .commit_fired   (commit_fired),
      .verdict_req    (verdict_req),
      .verdict_ack    (verdict_ack),
      .verdict_stream (verdict_stream),
      .verdict_fired  (verdict_fired),
      .drop_count     (drop_count)
   );

endmodule

// File: tb/ids_tb.sv
module ids_tb;

   import ids_pkg::*;

   localparam int          TIMEOUT_CYCLES = 50;
   localparam int          MAX_BYTES      = 64;
   // x^32 + x^22 + x^2 + x + 1, Galois form
   localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

   logic                clk;
   logic                rst_n;
   logic [7:0]          char_in;
   logic                char_in_vld;
   logic                eop;
   logic                load_state;
   logic [STREAM_W-1:0] stream_id;
   logic                new_stream_id;
   logic                enable;
   logic                verdict_req;
   logic                verdict_ack;
   logic [STREAM_W-1:0] verdict_stream;
   logic                verdict_fired;
   logic [COUNT_W-1:0]  count_out;
   logic [DROP_W-1:0]   drop_count;

   // Reference model, per-stream keyword progress and counters
   int          model_state [NUM_STREAMS];
   int          model_count;
   int          model_drops;
   string       keyword = "rlogin";
   logic [7:0]  pkt_bytes [MAX_BYTES];
   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          tests;
   bit          timed_out;
   // Verdict held back by a stalled ack
   bit          pending;
   int          pend_stream;
   logic        pend_fired;

   ids_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .char_in        (char_in),
      .char_in_vld    (char_in_vld),
      .eop            (eop),
      .load_state     (load_state),
      .stream_id      (stream_id),
      .new_stream_id  (new_stream_id),
      .enable         (enable),
      .verdict_req    (verdict_req),
      .verdict_ack    (verdict_ack),
      .verdict_stream (verdict_stream),
      .verdict_fired  (verdict_fired),
      .count_out      (count_out),
      .drop_count     (drop_count)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   // Idle cycles before a byte, two LFSR bits, one step per bit
   function int random_gap();
      int gap;
      int k;
      gap = 0;
      for (k = 0; k < 2; k++)
      begin
         gap  = (gap << 1) | lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
      return gap;
   endfunction

   task check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // Case folded keyword search, any hit in the packet fires it
   function automatic logic model_packet(input int sid, input bit nw, input bit en, input int n);
      int         s;
      int         i;
      logic       fired;
      logic [7:0] c;
      s     = nw ? 0 : model_state[sid];
      fired = 1'b0;
      for (i = 0; i < n; i++)
      begin
         c = pkt_bytes[i];
         if ((c >= 8'h41) && (c <= 8'h5a))
         begin
            c = c + 8'h20;
         end
         if (c == keyword[s])
         begin
            if (s == 5)
            begin
               fired = 1'b1;
               s     = 0;
            end
            else
            begin
               s++;
            end
         end
         else
         begin
            s = (c == "r") ? 1 : 0;
         end
      end
      // Disabled packets leave state and count alone
      if (en)
      begin
         model_state[sid] = s;
         model_count      = model_count + fired;
      end
      return en & fired;
   endfunction

   // Polls at edge plus one so the reporter outputs have settled
   task wait_req(input logic level, input string what);
      int n;
      n = 0;
      while ((verdict_req !== level) && (n < TIMEOUT_CYCLES))
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (verdict_req !== level)
      begin
         timed_out = 1'b1;
         errors++;
         $display("Timed out waiting for verdict_req to %s", what);
      end
   endtask

   task drive_packet(input int sid, input bit nw, input bit en, input int n);
      int gap;
      int i;
      load_state    = 1'b1;
      stream_id     = sid[STREAM_W-1:0];
      new_stream_id = nw;
      enable        = en;
      @(posedge clk);
      #1;
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      enable        = 1'b0;
      for (i = 0; i < n; i++)
      begin
         gap = random_gap();
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
         char_in     = pkt_bytes[i];
         char_in_vld = 1'b1;
         eop         = (i == n - 1);
         @(posedge clk);
         #1;
         char_in_vld = 1'b0;
         eop         = 1'b0;
      end
   endtask

   // Full four-phase close of the verdict on the port
   task ack_verdict();
      verdict_ack = 1'b1;
      wait_req(1'b0, "fall after ack");
      verdict_ack = 1'b0;
      @(posedge clk);
      #1;
      pending = 1'b0;
   endtask

   task run_packet(input string name, input int sid, input bit nw, input bit en,
                   input bit stall, input int n, input int exp_fired);
      int   err_before;
      logic fired;
      err_before = errors;
      tests++;
      fired = model_packet(sid, nw, en, n);
      check("file fired", fired, exp_fired);
      drive_packet(sid, nw, en, n);
      if (pending)
      begin
         // Reporter still busy, this commit must be dropped
         model_drops++;
         repeat (2) @(posedge clk);
         #1;
         check("drop_count", drop_count, model_drops);
         check("count_out", count_out, model_count);
         check("verdict_req", verdict_req, 1);
         check("verdict_stream", verdict_stream, pend_stream);
         check("verdict_fired", verdict_fired, pend_fired);
         ack_verdict();
      end
      else
      begin
         wait_req(1'b1, "rise");
         if (!timed_out)
         begin
            check("verdict_stream", verdict_stream, sid);
            check("verdict_fired", verdict_fired, fired);
            check("count_out", count_out, model_count);
            check("drop_count", drop_count, model_drops);
            if (stall)
            begin
               pending     = 1'b1;
               pend_stream = sid;
               pend_fired  = fired;
            end
            else
            begin
               ack_verdict();
            end
         end
      end
      if (errors == err_before)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d error(s)", name, errors - err_before);
      end
   endtask

   initial
   begin
      int         fd;
      int         code;
      int         sid;
      int         nw;
      int         en;
      int         n;
      int         exp_fired;
      int         i;
      logic [7:0] b;
      string      name;
      string      mode;
      string      hex;
      string      rest;
      clk           = 1'b0;
      rst_n         = 1'b0;
      char_in       = 8'h00;
      char_in_vld   = 1'b0;
      eop           = 1'b0;
      load_state    = 1'b0;
      stream_id     = '0;
      new_stream_id = 1'b0;
      enable        = 1'b0;
      verdict_ack   = 1'b0;
      lfsr          = 32'hd242;
      model_count   = 0;
      model_drops   = 0;
      errors        = 0;
      checks        = 0;
      tests         = 0;
      timed_out     = 1'b0;
      pending       = 1'b0;
      for (i = 0; i < NUM_STREAMS; i++)
      begin
         model_state[i] = 0;
      end
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      fd = $fopen("tb/ids_input.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Could not open the stimulus file tb/ids_input.txt");
      end
      else
      begin
         while (!timed_out)
         begin
            code = $fscanf(fd, "%s", name);
            if (code != 1)
            begin
               break;
            end
            // Comment line, skip the rest of it
            if (name[0] == "#")
            begin
               void'($fgets(rest, fd));
               continue;
            end
            code = $fscanf(fd, "%d %d %d %s %d %s %d", sid, nw, en, mode, n, hex, exp_fired);
            if ((code != 7) || (n < 1) || (n > MAX_BYTES) || (hex.len() != 2 * n))
            begin
               errors++;
               $display("Stimulus line for %s is malformed", name);
               break;
            end
            for (i = 0; i < n; i++)
            begin
               code = $sscanf(hex.substr(2 * i, 2 * i + 1), "%h", b);
               pkt_bytes[i] = b;
            end
            run_packet(name, sid, nw, en, (mode == "stalled"), n, exp_fired);
         end
         $fclose(fd);
      end
      if (pending && !timed_out)
      begin
         ack_verdict();
      end
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if ((errors == 0) && (tests > 0))
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
rtl/ids_pkg.sv
rtl/byte_class_decoder.sv
rtl/keyword_dfa.sv
rtl/stream_match_ctx.sv
rtl/verdict_reporter.sv
rtl/ids_top.sv
tb/ids_tb.sv

// File: Bender.yml
package:
  name: ids_rlogin

sources:
  - target: any(rtl, tb, simulation, synthesis)
    files:
      - rtl/ids_pkg.sv
      - rtl/byte_class_decoder.sv
      - rtl/keyword_dfa.sv
      - rtl/stream_match_ctx.sv
      - rtl/verdict_reporter.sv
      - rtl/ids_top.sv
  - target: any(tb, simulation)
    files:
      - tb/ids_tb.sv

// File: tb/ids_input.txt
# name stream new enable ack(prompt|stalled) nbytes hexbytes expected_fired
# hexbytes is the packet as one run of two-digit hex values, first byte first
# Mixed case keyword on a new stream
mixed_case 1 1 1 prompt 8 78524c6f47694e79 1
# Keyword split over two packets of one stream
split_a 2 1 1 prompt 5 6162726c6f 0
split_b 2 0 1 prompt 4 67696e21 1
# Interleaved streams keep separate progress
cross_a 3 1 1 prompt 5 78726c6f67 0
cross_b 4 1 1 prompt 2 696e 0
cross_c 3 0 1 prompt 3 696e2e 1
# Disabled packet neither counts nor saves its state
dis_pre 5 1 1 prompt 2 726c 0
dis_mid 5 0 0 prompt 6 726c6f67696e 0
dis_post 5 0 1 prompt 4 6f67696e 1
# New stream flag throws away the saved prefix
new_a 6 1 1 prompt 4 726c6f67 0
new_b 6 1 1 prompt 3 696e20 0
# Overlap and restart rules
overlap_rr 7 1 1 prompt 7 72726c6f67696e 1
overlap_rlo 8 1 1 prompt 9 726c6f726c6f67696e 1
near_miss 9 1 1 prompt 5 726c6f676e 0
twice 63 1 1 prompt 13 726c6f67696e2d524c4f47494e 1
# Stalled ack, the second verdict is dropped
stall_first 10 1 1 stalled 5 68656c6c6f 0
stall_dropped 11 1 1 prompt 6 524c4f47494e 1
after_stall 12 1 1 prompt 6 526c6f67694e 1
